// File: bridge_pkg.sv
// --------------------------------------------------------------------
// AXI4 to APB bridge definitions
// Widths, response codes and the request payloads held in the FIFOs
// --------------------------------------------------------------------
package bridge_pkg;

    // ----------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------
    localparam int ADDR_W     = 32;  // AXI and APB address
    localparam int AXI_DATA_W = 64;
    localparam int APB_DATA_W = 32;
    localparam int ID_W       = 4;
    localparam int FIFO_DEPTH = 4;   // Entries per channel FIFO

    // AXI size code of a full 8 byte access
    localparam logic [2:0] SIZE_64 = 3'd3;

    // ----------------------------------------------------------------
    // Response codes
    // ----------------------------------------------------------------
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ----------------------------------------------------------------
    // Channel payloads
    // ----------------------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;   // Single beat only
        logic [2:0]        size;
    } ar_req_t;

    // Write address has the same fields as read address
    typedef ar_req_t aw_req_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic                  last;  // Always set for a single beat
    } w_beat_t;

endpackage

// File: chan_fifo.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Channel FIFO
// Small circular buffer between one AXI request channel and the
// APB sequencer, shared by the AW, W and AR channels
// --------------------------------------------------------------------
module chan_fifo
    import bridge_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic     ACLK,
    input  logic     ARESETn,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     not_full_o,
    output logic     head_valid_o,
    output payload_t head_data_o
);

    payload_t                          mem_q [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr_q;
    logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr_q;
    logic [$clog2(FIFO_DEPTH+1)-1:0]   count_q;

    assign not_full_o   = (count_q != FIFO_DEPTH);
    assign head_valid_o = (count_q != '0);
    assign head_data_o  = mem_q[rd_ptr_q];

    // ----------------------------------------------------------------
    // Pointers and fill level
    // ----------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_DEPTH-1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle or push with pop
            endcase
        end
    end

    // Storage
    always_ff @(posedge ACLK) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // ----------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------
    a_no_overflow : assert property (@(posedge ACLK) disable iff (!ARESETn)
        push_i |-> not_full_o)
        else $error("chan_fifo push while full");

    a_no_underflow : assert property (@(posedge ACLK) disable iff (!ARESETn)
        pop_i |-> head_valid_o)
        else $error("chan_fifo pop while empty");

endmodule

// File: apb_sequencer.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// APB sequencer
// Turns one AXI request into one or two 32-bit APB transfers and
// gathers the read words into a 64-bit beat
// --------------------------------------------------------------------
module apb_sequencer
    import bridge_pkg::*;
(
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // Request heads
    input  logic                  ar_valid_i,
    input  ar_req_t               ar_req_i,
    input  logic                  aw_valid_i,
    input  aw_req_t               aw_req_i,
    input  logic                  w_valid_i,
    input  w_beat_t               w_beat_i,
    output logic                  ar_pop_o,
    output logic                  aw_pop_o,
    output logic                  w_pop_o,
    // Response slot status
    input  logic                  r_busy_i,
    input  logic                  b_busy_i,
    // APB
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_W-1:0]     paddr_o,
    output logic [APB_DATA_W-1:0] pwdata_o,
    input  logic [APB_DATA_W-1:0] prdata_i,
    input  logic                  pready_i,
    // Response loads
    output logic                  r_load_o,
    output logic [ID_W-1:0]       r_id_o,
    output logic [AXI_DATA_W-1:0] r_data_o,
    output logic                  b_load_o,
    output logic [ID_W-1:0]       b_id_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_FIRST, ST_SECOND, ST_LOAD} state_e;

    state_e                state_q, state_d;
    logic                  wr_q;       // Held request is a write
    ar_req_t               req_q;      // Held id, address and size
    logic [AXI_DATA_W-1:0] wdata_q;
    logic [AXI_DATA_W-1:0] rdata_q;
    logic                  start_rd;
    logic                  start_wr;
    logic                  is_64;
    logic                  word_sel;   // Upper 32-bit half in use

    // Reads win over writes, a write needs both address and data
    assign start_rd = (state_q == ST_IDLE) && ar_valid_i && !r_busy_i;
    assign start_wr = (state_q == ST_IDLE) && !start_rd
                      && aw_valid_i && w_valid_i && !b_busy_i;

    assign is_64    = (req_q.size == SIZE_64);
    assign word_sel = (state_q == ST_SECOND) || (!is_64 && req_q.addr[2]);

    // ----------------------------------------------------------------
    // APB drive
    // ----------------------------------------------------------------
    assign penable_o = (state_q == ST_FIRST) || (state_q == ST_SECOND);
    assign pwrite_o  = wr_q;
    assign paddr_o   = {req_q.addr[ADDR_W-1:3], word_sel,
                        is_64 ? 2'b00 : req_q.addr[1:0]};  // Aligned word first
    assign pwdata_o  = wdata_q[word_sel*APB_DATA_W +: APB_DATA_W];

    // Load strobes double as FIFO pops
    assign r_load_o = (state_q == ST_LOAD) && !wr_q;
    assign b_load_o = (state_q == ST_LOAD) && wr_q;
    assign r_id_o   = req_q.id;
    assign b_id_o   = req_q.id;
    assign r_data_o = rdata_q;
    assign ar_pop_o = r_load_o;
    assign aw_pop_o = b_load_o;
    assign w_pop_o  = b_load_o;

    // ----------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_rd || start_wr) state_d = ST_FIRST;
            end
            ST_FIRST: begin
                if (pready_i) state_d = is_64 ? ST_SECOND : ST_LOAD;
            end
            ST_SECOND: begin
                if (pready_i) state_d = ST_LOAD;
            end
            default: state_d = ST_IDLE;  // Load lasts one cycle
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= ST_IDLE;
            wr_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_rd || start_wr) wr_q <= start_wr;
        end
    end

    // Request capture and read word gathering
    always_ff @(posedge ACLK) begin
        if (start_rd) begin
            req_q   <= ar_req_i;
            rdata_q <= '0;  // Unused half of a narrow read reads as zero
        end else if (start_wr) begin
            req_q   <= aw_req_i;
            wdata_q <= w_beat_i.data;
        end else if (penable_o && pready_i && !wr_q) begin
            rdata_q[word_sel*APB_DATA_W +: APB_DATA_W] <= prdata_i;
        end
    end

    // ----------------------------------------------------------------
    // Single beat requests only
    // ----------------------------------------------------------------
    a_ar_single : assert property (@(posedge ACLK) disable iff (!ARESETn)
        start_rd |-> (ar_req_i.len == '0))
        else $error("AR len %0d unsupported, would need SLVERR (%0d)",
                    ar_req_i.len, RESP_SLVERR);

    a_aw_single : assert property (@(posedge ACLK) disable iff (!ARESETn)
        start_wr |-> (aw_req_i.len == '0) && w_beat_i.last)
        else $error("AW len %0d or missing WLAST unsupported, would need SLVERR (%0d)",
                    aw_req_i.len, RESP_SLVERR);

endmodule

// File: resp_slot.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// Response stage
// Holds one R beat and one B beat until the AXI master takes them
// --------------------------------------------------------------------
module resp_slot
    import bridge_pkg::*;
(
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // From the sequencer
    input  logic                  r_load_i,
    input  logic [ID_W-1:0]       r_id_i,
    input  logic [AXI_DATA_W-1:0] r_data_i,
    input  logic                  b_load_i,
    input  logic [ID_W-1:0]       b_id_i,
    output logic                  r_busy_o,
    // AXI read data
    output logic                  rvalid_o,
    output logic [ID_W-1:0]       rid_o,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic [1:0]            rresp_o,
    output logic                  rlast_o,
    input  logic                  rready_i,
    // AXI write response
    output logic                  bvalid_o,
    output logic [ID_W-1:0]       bid_o,
    output logic [1:0]            bresp_o,
    input  logic                  bready_i
);

    logic r_full_q;
    logic b_full_q;

    assign r_busy_o = r_full_q;
    assign rvalid_o = r_full_q;
    assign rlast_o  = r_full_q;    // Every beat is the last one
    assign rresp_o  = RESP_OKAY;
    assign bvalid_o = b_full_q;
    assign bresp_o  = RESP_OKAY;

    // ----------------------------------------------------------------
    // Full flags
    // ----------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            r_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            if (r_load_i)      r_full_q <= 1'b1;
            else if (rready_i) r_full_q <= 1'b0;  // Slot empties on handshake
            if (b_load_i)      b_full_q <= 1'b1;
            else if (bready_i) b_full_q <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge ACLK) begin
        if (r_load_i) begin
            rid_o   <= r_id_i;
            rdata_o <= r_data_i;
        end
        if (b_load_i) bid_o <= b_id_i;
    end

    // The sequencer must see busy before starting another request
    a_r_no_overwrite : assert property (@(posedge ACLK) disable iff (!ARESETn)
        r_load_i |-> !r_full_q)
        else $error("R slot loaded while full");

    a_b_no_overwrite : assert property (@(posedge ACLK) disable iff (!ARESETn)
        b_load_i |-> !b_full_q)
        else $error("B slot loaded while full");

endmodule

// File: axi2apb_bridge.sv
`timescale 1ns/1ps
// --------------------------------------------------------------------
// AXI4 to APB bridge
// 64-bit single beat AXI4 slave to 32-bit APB master
// --------------------------------------------------------------------
module axi2apb_bridge
    import bridge_pkg::*;
(
    input  logic                  ACLK,
    input  logic                  ARESETn,
    // AXI write address
    input  logic                  awvalid_i,
    output logic                  awready_o,
    input  logic [ID_W-1:0]       awid_i,
    input  logic [ADDR_W-1:0]     awaddr_i,
    input  logic [7:0]            awlen_i,
    input  logic [2:0]            awsize_i,
    // AXI write data
    input  logic                  wvalid_i,
    output logic                  wready_o,
    input  logic [AXI_DATA_W-1:0] wdata_i,
    input  logic                  wlast_i,
    // AXI write response
    output logic                  bvalid_o,
    input  logic                  bready_i,
    output logic [ID_W-1:0]       bid_o,
    output logic [1:0]            bresp_o,
    // AXI read address
    input  logic                  arvalid_i,
    output logic                  arready_o,
    input  logic [ID_W-1:0]       arid_i,
    input  logic [ADDR_W-1:0]     araddr_i,
    input  logic [7:0]            arlen_i,
    input  logic [2:0]            arsize_i,
    // AXI read data
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic [ID_W-1:0]       rid_o,
    output logic [AXI_DATA_W-1:0] rdata_o,
    output logic [1:0]            rresp_o,
    output logic                  rlast_o,
    // APB
    output logic                  penable_o,
    output logic                  pwrite_o,
    output logic [ADDR_W-1:0]     paddr_o,
    output logic [APB_DATA_W-1:0] pwdata_o,
    input  logic [APB_DATA_W-1:0] prdata_i,
    input  logic                  pready_i
);

    // ----------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------
    aw_req_t               aw_in, aw_head;
    ar_req_t               ar_in, ar_head;
    w_beat_t               w_in, w_head;
    logic                  aw_valid, w_valid, ar_valid;
    logic                  aw_pop, w_pop, ar_pop;
    logic                  r_busy, b_busy;
    logic                  r_load, b_load;
    logic [ID_W-1:0]       r_id, b_id;
    logic [AXI_DATA_W-1:0] r_data;

    assign aw_in = '{id: awid_i, addr: awaddr_i, len: awlen_i, size: awsize_i};
    assign ar_in = '{id: arid_i, addr: araddr_i, len: arlen_i, size: arsize_i};
    assign w_in  = '{data: wdata_i, last: wlast_i};

    // Input side
    chan_fifo #(.payload_t(aw_req_t)) aw_fifo (
        .ACLK, .ARESETn,
        .push_i (awvalid_i & awready_o), .push_data_i (aw_in), .pop_i (aw_pop),
        .not_full_o (awready_o), .head_valid_o (aw_valid), .head_data_o (aw_head)
    );

    chan_fifo #(.payload_t(w_beat_t)) w_fifo (
        .ACLK, .ARESETn,
        .push_i (wvalid_i & wready_o), .push_data_i (w_in), .pop_i (w_pop),
        .not_full_o (wready_o), .head_valid_o (w_valid), .head_data_o (w_head)
    );

    chan_fifo #(.payload_t(ar_req_t)) ar_fifo (
        .ACLK, .ARESETn,
        .push_i (arvalid_i & arready_o), .push_data_i (ar_in), .pop_i (ar_pop),
        .not_full_o (arready_o), .head_valid_o (ar_valid), .head_data_o (ar_head)
    );

    // Processing
    apb_sequencer u_seq (
        .ACLK, .ARESETn,
        .ar_valid_i (ar_valid), .ar_req_i (ar_head),
        .aw_valid_i (aw_valid), .aw_req_i (aw_head),
        .w_valid_i  (w_valid),  .w_beat_i (w_head),
        .ar_pop_o (ar_pop), .aw_pop_o (aw_pop), .w_pop_o (w_pop),
        .r_busy_i (r_busy), .b_busy_i (b_busy),
        .penable_o, .pwrite_o, .paddr_o, .pwdata_o, .prdata_i, .pready_i,
        .r_load_o (r_load), .r_id_o (r_id), .r_data_o (r_data),
        .b_load_o (b_load), .b_id_o (b_id)
    );

    // Output side
    resp_slot u_resp (
        .ACLK, .ARESETn,
        .r_load_i (r_load), .r_id_i (r_id), .r_data_i (r_data),
        .b_load_i (b_load), .b_id_i (b_id), .r_busy_o (r_busy),
        .rvalid_o, .rid_o, .rdata_o, .rresp_o, .rlast_o, .rready_i,
        .bvalid_o, .bid_o, .bresp_o, .bready_i
    );

    assign b_busy = bvalid_o;  // B slot full flag drives bvalid

endmodule

// File: tb_apb_mem.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// APB slave model for the bridge testbench
// Word memory behind a one-phase APB port with random pready stalls
// ----------------------------------------------------------------------
module tb_apb_mem
    import bridge_pkg::*;
#(
    parameter int SEED = 47
) (
    input  logic                  ACLK,
    input  logic                  ARESETn,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [ADDR_W-1:0]     paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o = 1'b0
);

    logic [APB_DATA_W-1:0] mem [16];   // Small window, word indexed
    integer                seed = SEED;
    integer                r;

    assign prdata_o = mem[paddr_i[5:2]];

    // Fill pattern on reset, writes on a completed transfer
    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 32'ha5a5_0000 ^ (32'h0001_0203 * (i + 1));
            end
        end else if (penable_i && pwrite_i && pready_o) begin
            mem[paddr_i[5:2]] <= pwdata_i;
        end
    end

    // Ready three cycles out of four on average
    always @(posedge ACLK) begin
        #1;
        r        = $random(seed);
        pready_o = (r[1:0] != 2'b00);
    end

endmodule

// File: tb_axi2apb.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// AXI4 to APB bridge testbench
// Random single beat traffic checked against a word memory model
// ----------------------------------------------------------------------
module tb_axi2apb
    import bridge_pkg::*;
;

    localparam int          CLK_PERIOD = 8;
    localparam int          N_RANDOM   = 200;
    localparam int          N_OPS      = N_RANDOM + 7;  // Random plus directed
    localparam logic [31:0] BASE       = 32'h0000_4000;

    typedef struct packed {
        logic [ID_W-1:0]       id;
        logic [ADDR_W-1:0]     addr;
        logic [APB_DATA_W-1:0] data;
        logic                  half;  // Upper half of the AXI beat
        logic                  last;  // Last transfer of its access
    } xfer_t;

    typedef struct packed {
        logic [ID_W-1:0]       id;
        logic [AXI_DATA_W-1:0] data;
    } rbeat_t;

    logic ACLK = 1'b0;
    logic ARESETn;
    logic awvalid_i, wvalid_i, arvalid_i, wlast_i;
    logic awready_o, wready_o, arready_o;
    logic rready_i = 1'b0;
    logic bready_i = 1'b0;
    logic [ID_W-1:0] awid_i, arid_i, bid_o, rid_o;
    logic [ADDR_W-1:0] awaddr_i, araddr_i, paddr_o;
    logic [7:0] awlen_i, arlen_i;
    logic [2:0] awsize_i, arsize_i;
    logic [AXI_DATA_W-1:0] wdata_i, rdata_o;
    logic bvalid_o, rvalid_o, rlast_o, penable_o, pwrite_o, pready_i;
    logic [1:0] bresp_o, rresp_o;
    logic [APB_DATA_W-1:0] pwdata_o, prdata_i;

    // Model state
    logic [APB_DATA_W-1:0] model_mem [16];
    xfer_t                 rd_xfers[$];
    xfer_t                 wr_xfers[$];
    rbeat_t                exp_r[$];
    logic [ID_W-1:0]       exp_b[$];
    logic [AXI_DATA_W-1:0] rd_acc = '0;
    logic pair_open = 1'b0;
    logic pair_wr = 1'b0;
    logic r_hold = 1'b0;
    logic b_hold = 1'b0;
    logic saw_full = 1'b0;
    logic [ID_W-1:0] r_hold_id, b_hold_id;
    logic [AXI_DATA_W-1:0] r_hold_data;
    int ar_accepted = 0;       // Read requests taken by the bridge
    int rd_started = 0;        // Reads whose first APB word has begun
    logic rd_first_due = 1'b0; // A read could start in the last cycle
    logic pen_q = 1'b0;
    int checks = 0;
    int errors = 0;
    int test_err_base = 0;
    integer seed;
    integer stall_seed = 47;
    integer stall_r;
    int r_span = 0;
    int b_span = 0;

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    axi2apb_bridge uut (.*);

    tb_apb_mem #(.SEED(47)) apb_mem (
        .ACLK, .ARESETn, .penable_i (penable_o), .pwrite_i (pwrite_o),
        .paddr_i (paddr_o), .pwdata_i (pwdata_o),
        .prdata_o (prdata_i), .pready_o (pready_i)
    );

    // ------------------------------------------------------------------
    // Check helpers
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("At %0d ns: %s", $time, what);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d errors", name,
                 (errors == test_err_base) ? "ok" : "fail", errors - test_err_base);
        test_err_base = errors;
    endtask

    // ------------------------------------------------------------------
    // Monitors sampled mid-cycle
    // ------------------------------------------------------------------
    task automatic check_apb();
        xfer_t  x;
        rbeat_t rb;
        logic   have;
        have = pwrite_o ? (wr_xfers.size() != 0) : (rd_xfers.size() != 0);
        check_true(have, "APB transfer seen with no matching access outstanding");
        check_true(!pair_open || (pwrite_o == pair_wr),
                   "second word of a 64-bit access did not follow the first");
        if (!have) return;
        if (pwrite_o) x = wr_xfers.pop_front();
        else x = rd_xfers.pop_front();
        check_value("paddr_o", 64'(paddr_o), 64'(x.addr));
        if (pwrite_o) begin
            check_value("pwdata_o", 64'(pwdata_o), 64'(x.data));
            model_mem[x.addr[5:2]] = x.data;
        end else begin
            if (x.half) rd_acc[63:32] = model_mem[x.addr[5:2]];
            else rd_acc[31:0] = model_mem[x.addr[5:2]];
            if (x.last) begin
                rb.id   = x.id;
                rb.data = rd_acc;
                exp_r.push_back(rb);
                rd_acc = '0;                     // Narrow reads leave one half zero
            end
        end
        pair_open = !x.last;
        pair_wr   = pwrite_o;
    endtask

    task automatic check_resp();
        rbeat_t e;
        if (r_hold) begin
            check_true(rvalid_o, "rvalid_o dropped before the handshake");
            check_value("rid_o", 64'(rid_o), 64'(r_hold_id));
            check_value("rdata_o", rdata_o, r_hold_data);
        end
        if (b_hold) begin
            check_true(bvalid_o, "bvalid_o dropped before the handshake");
            check_value("bid_o", 64'(bid_o), 64'(b_hold_id));
        end
        if (rvalid_o && rready_i) begin
            check_true(exp_r.size() != 0, "R beat returned with no read outstanding");
            if (exp_r.size() != 0) begin
                e = exp_r.pop_front();
                check_value("rid_o", 64'(rid_o), 64'(e.id));
                check_value("rdata_o", rdata_o, e.data);
                check_value("rresp_o", 64'(rresp_o), 64'(RESP_OKAY));
                check_value("rlast_o", 64'(rlast_o), 64'(1'b1));
            end
        end
        if (bvalid_o && bready_i) begin
            check_true(exp_b.size() != 0, "B response returned with no write outstanding");
            if (exp_b.size() != 0) begin
                check_value("bid_o", 64'(bid_o), 64'(exp_b.pop_front()));
                check_value("bresp_o", 64'(bresp_o), 64'(RESP_OKAY));
            end
        end
        r_hold      = rvalid_o && !rready_i;
        r_hold_id   = rid_o;
        r_hold_data = rdata_o;
        b_hold      = bvalid_o && !bready_i;
        b_hold_id   = bid_o;
    endtask

    always @(negedge ACLK) begin
        if (ARESETn) begin
            // A rising penable starts an access chosen in the cycle before
            if (penable_o && !pen_q) begin
                if (rd_first_due) begin
                    check_true(!pwrite_o, "write started while a read waited with the R slot free");
                end
                if (!pwrite_o) rd_started++;
            end
            rd_first_due = (ar_accepted > rd_started) && !rvalid_o;
            if (arvalid_i && arready_o) ar_accepted++;   // Visible after the next edge
            pen_q = penable_o;
            if (penable_o && pready_i) check_apb();   // Completes at the next edge
            check_resp();
            if (!awready_o || !wready_o || !arready_o) saw_full = 1'b1;
        end
    end

    // Response back-pressure in random spans of up to 32 cycles
    always @(posedge ACLK) begin
        #1;
        stall_r = $random(stall_seed);
        if (r_span == 0) begin
            rready_i = stall_r[5];
            r_span   = int'(stall_r[4:0]) + 1;
        end else begin
            r_span = r_span - 1;
        end
        if (b_span == 0) begin
            bready_i = stall_r[13];
            b_span   = int'(stall_r[12:8]) + 1;
        end else begin
            b_span = b_span - 1;
        end
    end

    // ------------------------------------------------------------------
    // AXI drivers entered one step after a rising edge
    // ------------------------------------------------------------------
    task automatic drive_write(input logic [3:0] id, input logic [31:0] addr,
                               input logic [2:0] size, input logic [63:0] data);
        logic aw_done;
        logic w_done;
        aw_done   = 1'b0;
        w_done    = 1'b0;
        awvalid_i = 1'b1;
        awid_i    = id;
        awaddr_i  = addr;
        awlen_i   = 8'd0;
        awsize_i  = size;
        wvalid_i  = 1'b1;
        wdata_i   = data;
        wlast_i   = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge ACLK);
            if (awvalid_i && awready_o) aw_done = 1'b1;
            if (wvalid_i && wready_o) w_done = 1'b1;
            @(posedge ACLK);
            #1;
            if (aw_done) awvalid_i = 1'b0;
            if (w_done) wvalid_i = 1'b0;
        end
    endtask

    task automatic drive_read(input logic [3:0] id, input logic [31:0] addr,
                              input logic [2:0] size);
        arvalid_i = 1'b1;
        arid_i    = id;
        araddr_i  = addr;
        arlen_i   = 8'd0;
        arsize_i  = size;
        do @(negedge ACLK); while (!arready_o);
        @(posedge ACLK);
        #1;
        arvalid_i = 1'b0;
    endtask

    // Queue the APB transfers the access maps to, then issue it
    task automatic do_op(input logic wr, input logic [3:0] id, input logic [31:0] addr,
                         input logic [2:0] size, input logic [63:0] data);
        xfer_t x;
        logic  is_64;
        is_64  = (size == SIZE_64);
        x.id   = id;
        x.half = is_64 ? 1'b0 : addr[2];
        x.addr = is_64 ? {addr[31:3], 3'b000} : addr;
        x.data = x.half ? data[63:32] : data[31:0];
        x.last = !is_64;
        if (wr) wr_xfers.push_back(x);
        else rd_xfers.push_back(x);
        if (is_64) begin
            x.half = 1'b1;
            x.addr = x.addr + 32'd4;          // Upper word follows
            x.data = data[63:32];
            x.last = 1'b1;
            if (wr) wr_xfers.push_back(x);
            else rd_xfers.push_back(x);
        end
        if (wr) begin
            exp_b.push_back(id);
            drive_write(id, addr, size, data);
        end else begin
            drive_read(id, addr, size);
        end
    endtask

    task automatic wait_idle();
        do @(posedge ACLK);
        while (rd_xfers.size() != 0 || wr_xfers.size() != 0 ||
               exp_r.size() != 0 || exp_b.size() != 0);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        integer r;
        integer d_hi;
        integer d_lo;
        ARESETn   = 1'b0;
        awvalid_i = 1'b0;
        awid_i    = '0;
        awaddr_i  = '0;
        awlen_i   = '0;
        awsize_i  = '0;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wlast_i   = 1'b0;
        arvalid_i = 1'b0;
        arid_i    = '0;
        araddr_i  = '0;
        arlen_i   = '0;
        arsize_i  = '0;
        seed      = 47;
        for (int i = 0; i < 16; i++) begin
            model_mem[i] = 32'ha5a5_0000 ^ (32'h0001_0203 * (i + 1));
        end
        repeat (10) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;

        @(negedge ACLK);
        check_value("rvalid_o", 64'(rvalid_o), 64'(1'b0));
        check_value("bvalid_o", 64'(bvalid_o), 64'(1'b0));
        check_value("penable_o", 64'(penable_o), 64'(1'b0));
        check_value("awready_o", 64'(awready_o), 64'(1'b1));
        check_value("wready_o", 64'(wready_o), 64'(1'b1));
        check_value("arready_o", 64'(arready_o), 64'(1'b1));
        end_test("reset values");
        @(posedge ACLK);
        #1;

        do_op(1'b1, 4'h3, BASE + 32'h08, SIZE_64, 64'h1122_3344_5566_7788);
        do_op(1'b0, 4'h9, BASE + 32'h08, SIZE_64, '0);
        wait_idle();
        end_test("64-bit write then read");

        do_op(1'b1, 4'h1, BASE + 32'h10, 3'd2, 64'hdead_beef_0bad_f00d);
        do_op(1'b1, 4'h2, BASE + 32'h14, 3'd2, 64'hcafe_f00d_1234_5678);
        wait_idle();                          // Reads must see both halves written
        do_op(1'b0, 4'h6, BASE + 32'h10, 3'd2, '0);
        do_op(1'b0, 4'h7, BASE + 32'h14, 3'd2, '0);
        do_op(1'b0, 4'h8, BASE + 32'h10, SIZE_64, '0);
        wait_idle();
        end_test("32-bit halves");

        repeat (N_RANDOM) begin
            r    = $random(seed);
            d_hi = $random(seed);
            d_lo = $random(seed);
            do_op(r[9], r[3:0], BASE + {26'd0, r[7:4], 2'b00},
                  r[8] ? SIZE_64 : 3'd2, {d_hi, d_lo});
        end
        wait_idle();
        check_true(saw_full, "AXI ready never fell although responses were stalled");
        end_test("random traffic with stalls");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial begin
        #(N_OPS * 200 * CLK_PERIOD);
        $display("Timeout: responses still outstanding after %0d ns", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: vlog.f
bridge_pkg.sv
chan_fifo.sv
apb_sequencer.sv
resp_slot.sv
axi2apb_bridge.sv
tb_apb_mem.sv
tb_axi2apb.sv

// File: run.sh
#!/bin/sh
# Build and run the AXI4 to APB bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 --top-module tb_axi2apb -f vlog.f

out=$(./obj_dir/Vtb_axi2apb)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"
